// ==== common/heartPkg.sv ====
/* Shared widths, FIR coefficient table and seven-segment codes for the monitor.
   Coefficients are the low-pass taps scaled by 1024; segment codes are active low. */
package heartPkg;

	// ADC frame and sample widths
	localparam int FrameBits = 16;
	localparam int SampleBits = 10;

	// FIR shape
	localparam int TapCount = 31;
	localparam int CoefShift = 10;

	typedef logic [FrameBits-1:0] frameT;
	typedef logic [SampleBits-1:0] sampleT;
	// wide enough for the saturated 31-tap sum
	typedef logic [19:0] accT;
	typedef logic [11:0] rateT;
	typedef logic [7:0] countT;
	typedef logic [3:0] digitT;
	typedef logic [6:0] segT;
	// one-hot, bit 0 is the ones digit
	typedef logic [2:0] selT;

	// entries 0..14 serve mirrored tap pairs, entry 15 is the centre tap
	localparam logic [6:0] CoefTable [16] = '{
		7'd3, 7'd4, 7'd6, 7'd8, 7'd12, 7'd17, 7'd23, 7'd29,
		7'd36, 7'd43, 7'd50, 7'd56, 7'd61, 7'd65, 7'd67, 7'd68
	};

	// hex digit patterns, segment g in bit 6
	localparam segT SegTable [16] = '{
		7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,
		7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000,
		7'b000_0000, 7'b001_1000, 7'b000_1000, 7'b000_0011,
		7'b010_0111, 7'b010_0001, 7'b000_0110, 7'b000_1110
	};

	// digit position shown by the display scan
	typedef enum logic [1:0] {
		scanOnes,
		scanTens,
		scanHundreds
	} scanStateT;

endpackage

// ==== verilog/spiFrameRx.sv ====
/* Frames are counted from the first sck edge after reset; no chip select.
   Only the low 10 bits of each 16-bit frame leave this block. */
`timescale 1ns/1ps

module spiFrameRx (
	input logic sck,
	input logic reset,
	input logic sdo,
	output heartPkg::sampleT sample,
	output logic sampleValid
);

	// position of the bit captured on the current edge
	logic [3:0] bitCount;
	// first 15 bits of the frame, MSB first
	logic [heartPkg::FrameBits-2:0] shiftReg;
	heartPkg::frameT frame;
	logic lastBit;

	// full frame as seen on the edge of its last bit
	assign frame = {shiftReg, sdo};
	assign lastBit = (bitCount == 4'd15);

	// bit counter wraps once per frame
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			bitCount <= '0;
			sampleValid <= 1'b0;
		end
		else
		begin
			bitCount <= bitCount + 4'd1;
			// strobe in the cycle after bit 15 lands
			sampleValid <= lastBit;
		end
	end

	// data path, no reset needed
	always_ff @(posedge sck)
	begin
		shiftReg <= frame[heartPkg::FrameBits-2:0];
		if (lastBit)
		begin
			// upper 6 bits are channel and padding
			sample <= frame[heartPkg::SampleBits-1:0];
		end
	end

endmodule

// ==== filter/firFilter.sv ====
/* Symmetric 31-tap low-pass FIR, one output per input strobe, 2 cycles of latency.
   Output is floor(sum / 1024) clamped to 1023. */
`timescale 1ns/1ps

module firFilter (
	input logic sck,
	input logic reset,
	input heartPkg::sampleT sample,
	input logic sampleValid,
	output heartPkg::sampleT filtered,
	output logic filteredValid
);

	localparam int AccBits = $bits(heartPkg::accT);
	localparam int HalfTaps = heartPkg::TapCount / 2;

	// delay line, highest index is the newest sample
	heartPkg::sampleT taps [heartPkg::TapCount];
	// delay line as it looks after the incoming sample
	heartPkg::sampleT nextTaps [heartPkg::TapCount];
	// one extra bit catches overflow of the full-scale sum
	logic [AccBits:0] sumWide;
	heartPkg::accT acc;
	logic accValid;

	// shifted view of the line
	always_comb
	begin
		for (int i = 0; i < heartPkg::TapCount - 1; i++)
		begin
			nextTaps[i] = taps[i+1];
		end
		nextTaps[heartPkg::TapCount-1] = sample;
	end

	// pre-add mirrored taps, then multiply-accumulate
	always_comb
	begin
		sumWide = '0;
		for (int k = 0; k < HalfTaps; k++)
		begin
			sumWide = sumWide + heartPkg::CoefTable[k]
				* ({1'b0, nextTaps[k]} + {1'b0, nextTaps[heartPkg::TapCount-1-k]});
		end
		// centre tap has no partner
		sumWide = sumWide + heartPkg::CoefTable[HalfTaps] * nextTaps[HalfTaps];
	end

	// delay line starts at zero
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < heartPkg::TapCount; i++)
			begin
				taps[i] <= '0;
			end
		end
		else if (sampleValid)
		begin
			taps <= nextTaps;
		end
	end

	// valid strobe pipeline
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			accValid <= 1'b0;
			filteredValid <= 1'b0;
		end
		else
		begin
			accValid <= sampleValid;
			filteredValid <= accValid;
		end
	end

	always_ff @(posedge sck)
	begin
		// stage 1, saturate so the later shift never exceeds 1023
		if (sampleValid)
		begin
			acc <= sumWide[AccBits] ? '1 : sumWide[AccBits-1:0];
		end
		// stage 2, drop the coefficient scale
		if (accValid)
		begin
			filtered <= heartPkg::sampleT'(acc >> heartPkg::CoefShift);
		end
	end

endmodule

// ==== peak/peakFinder.sv ====
/* Peak detector on the slope history of the filtered stream.
   WindowBits must be even; a peak blocks new peaks for HoldSamples filtered values. */
`timescale 1ns/1ps

module peakFinder #(
	parameter int WindowBits = 128,
	parameter int LeftMax = 55,
	parameter int RightMin = 40,
	parameter int HoldSamples = 128
) (
	input logic sck,
	input logic reset,
	input heartPkg::sampleT filtered,
	input logic filteredValid,
	output logic peakPulse,
	output logic peakLed,
	output heartPkg::countT peakCount
);

	localparam int HalfBits = WindowBits / 2;
	localparam int SumBits = $clog2(HalfBits + 1);
	localparam int HoldBits = $clog2(HoldSamples + 1);

	// bit 0 newest, 1 means the value did not rise
	logic [WindowBits-1:0] history;
	// ones in history[HalfBits-1:0]
	logic [SumBits-1:0] newerSum;
	// ones in history[WindowBits-1:HalfBits]
	logic [SumBits-1:0] olderSum;
	heartPkg::sampleT prevValue;
	logic [HoldBits-1:0] holdCount;
	logic slopeBit;
	logic midBit;
	logic oldestBit;
	logic holdActive;
	logic peakFire;

	assign slopeBit = (filtered <= prevValue);
	// bit moving from newer half into older half
	assign midBit = history[HalfBits-1];
	// bit leaving the window
	assign oldestBit = history[WindowBits-1];
	assign holdActive = (holdCount != '0);

	// long rise then a mostly flat or falling stretch
	assign peakFire = (olderSum <= LeftMax) && (newerSum >= RightMin) && !holdActive;

	// slope history and running half sums
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			history <= '1;
			newerSum <= SumBits'(HalfBits);
			olderSum <= SumBits'(HalfBits);
			prevValue <= '0;
		end
		else if (filteredValid)
		begin
			history <= {history[WindowBits-2:0], slopeBit};
			newerSum <= newerSum + SumBits'(slopeBit) - SumBits'(midBit);
			olderSum <= olderSum + SumBits'(midBit) - SumBits'(oldestBit);
			prevValue <= filtered;
		end
	end

	// peak decision, hold-off and running count
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			peakPulse <= 1'b0;
			peakCount <= '0;
			holdCount <= '0;
		end
		else
		begin
			peakPulse <= 1'b0;
			if (filteredValid)
			begin
				if (peakFire)
				begin
					peakPulse <= 1'b1;
					peakCount <= peakCount + 1'b1;
					holdCount <= HoldBits'(HoldSamples);
				end
				else if (holdActive)
				begin
					holdCount <= holdCount - 1'b1;
				end
			end
		end
	end

	// lit for the whole hold-off
	assign peakLed = holdActive;

endmodule

// ==== verilog/rateCounter.sv ====
/* Rate over a window of WindowSamples filtered values, saturated at 999 bpm.
   A peak from the value that closes a window is counted in the next window. */
`timescale 1ns/1ps

module rateCounter #(
	parameter int WindowSamples = 1250,
	parameter int RateScale = 6
) (
	input logic sck,
	input logic reset,
	input logic filteredValid,
	input logic peakPulse,
	output heartPkg::rateT bpm
);

	localparam int CountBits = $clog2(WindowSamples + 1);
	localparam int ProductBits = $bits(heartPkg::countT) + $clog2(RateScale + 1);
	localparam int RateMax = 999;

	logic [CountBits-1:0] sampleCount;
	heartPkg::countT windowPeaks;
	logic [ProductBits-1:0] scaled;
	logic windowClose;

	assign scaled = ProductBits'(windowPeaks) * ProductBits'(RateScale);
	assign windowClose = filteredValid && (sampleCount == CountBits'(WindowSamples - 1));

	// peakPulse trails filteredValid by one cycle, so the two never meet
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			sampleCount <= '0;
			windowPeaks <= '0;
			bpm <= '0;
		end
		else if (windowClose)
		begin
			bpm <= (scaled > RateMax) ? heartPkg::rateT'(RateMax) : heartPkg::rateT'(scaled);
			// fresh window
			sampleCount <= '0;
			windowPeaks <= '0;
		end
		else
		begin
			if (filteredValid)
			begin
				sampleCount <= sampleCount + 1'b1;
			end
			if (peakPulse)
			begin
				windowPeaks <= windowPeaks + 1'b1;
			end
		end
	end

endmodule

// ==== display/digitSplit.sv ====
/* Binary to three decimal digits by shift-and-add-3.
   Values above 999 show only their low three decimal digits. */
`timescale 1ns/1ps

module digitSplit (
	input heartPkg::rateT bpm,
	output heartPkg::digitT ones,
	output heartPkg::digitT tens,
	output heartPkg::digitT hundreds
);

	localparam int RateBits = $bits(heartPkg::rateT);
	localparam int DigitCount = 3;

	// packed decimal result, ones in the low nibble
	logic [4*DigitCount-1:0] bcd;

	always_comb
	begin
		bcd = '0;
		// walk the binary value from its MSB
		for (int i = RateBits - 1; i >= 0; i--)
		begin
			// adjust any digit that would pass 9 after doubling
			for (int d = 0; d < DigitCount; d++)
			begin
				if (bcd[4*d +: 4] >= 4'd5)
				begin
					bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
				end
			end
			// carry out of the hundreds digit is dropped
			bcd = {bcd[4*DigitCount-2:0], bpm[i]};
		end
	end

	assign ones = bcd[3:0];
	assign tens = bcd[7:4];
	assign hundreds = bcd[11:8];

endmodule

// ==== display/displayScan.sv ====
/* Multiplexes three seven-segment digits, ScanDivide sck cycles each.
   ScanDivide must be at least 2; disp and segments are active low. */
`timescale 1ns/1ps

module displayScan #(
	parameter int ScanDivide = 3000
) (
	input logic sck,
	input logic reset,
	input heartPkg::digitT ones,
	input heartPkg::digitT tens,
	input heartPkg::digitT hundreds,
	output heartPkg::selT disp,
	output heartPkg::segT sevenOut
);

	localparam int DivBits = $clog2(ScanDivide);

	logic [DivBits-1:0] divCount;
	heartPkg::scanStateT state;
	heartPkg::scanStateT nextState;
	heartPkg::digitT digit;
	heartPkg::selT select;
	logic slotEnd;

	assign slotEnd = (divCount == DivBits'(ScanDivide - 1));

	// scan order ones, tens, hundreds
	always_comb
	begin
		case (state)
			heartPkg::scanOnes: nextState = heartPkg::scanTens;
			heartPkg::scanTens: nextState = heartPkg::scanHundreds;
			default: nextState = heartPkg::scanOnes;
		endcase
	end

	// slot timer and digit position
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			divCount <= '0;
			state <= heartPkg::scanOnes;
		end
		else if (slotEnd)
		begin
			divCount <= '0;
			state <= nextState;
		end
		else
		begin
			divCount <= divCount + 1'b1;
		end
	end

	// digit mux and one-hot select
	always_comb
	begin
		case (state)
			heartPkg::scanTens:
			begin
				digit = tens;
				select = 3'b010;
			end
			heartPkg::scanHundreds:
			begin
				digit = hundreds;
				select = 3'b100;
			end
			default:
			begin
				digit = ones;
				select = 3'b001;
			end
		endcase
	end

	// common-anode drivers pull low
	assign disp = ~select;
	assign sevenOut = heartPkg::SegTable[digit];

endmodule

// ==== verilog/heartMonitor.sv ====
/* Heart rate monitor top on a single clock sck; the ADC sends a 16-bit frame every 16 cycles.
   leds shows the running peak count, bpm the last window's rate. */
`timescale 1ns/1ps

module heartMonitor #(
	parameter int WindowBits = 128,
	parameter int LeftMax = 55,
	parameter int RightMin = 40,
	parameter int HoldSamples = 128,
	parameter int WindowSamples = 1250,
	parameter int RateScale = 6,
	parameter int ScanDivide = 3000
) (
	input logic sck,
	input logic reset,
	input logic sdo,
	output logic peakLed,
	output heartPkg::countT leds,
	output heartPkg::rateT bpm,
	output heartPkg::selT disp,
	output heartPkg::segT sevenOut
);

	// sample strobes between stages
	heartPkg::sampleT sample;
	logic sampleValid;
	heartPkg::sampleT filtered;
	logic filteredValid;
	logic peakPulse;
	// decimal digits of bpm
	heartPkg::digitT ones;
	heartPkg::digitT tens;
	heartPkg::digitT hundreds;

	spiFrameRx spiFrameRx_inst (
		.sck(sck),
		.reset(reset),
		.sdo(sdo),
		.sample(sample),
		.sampleValid(sampleValid)
	);

	firFilter firFilter_inst (
		.sck(sck),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.filtered(filtered),
		.filteredValid(filteredValid)
	);

	// running peak count goes straight to the LEDs
	peakFinder #(
		.WindowBits(WindowBits),
		.LeftMax(LeftMax),
		.RightMin(RightMin),
		.HoldSamples(HoldSamples)
	) peakFinder_inst (
		.sck(sck),
		.reset(reset),
		.filtered(filtered),
		.filteredValid(filteredValid),
		.peakPulse(peakPulse),
		.peakLed(peakLed),
		.peakCount(leds)
	);

	rateCounter #(
		.WindowSamples(WindowSamples),
		.RateScale(RateScale)
	) rateCounter_inst (
		.sck(sck),
		.reset(reset),
		.filteredValid(filteredValid),
		.peakPulse(peakPulse),
		.bpm(bpm)
	);

	digitSplit digitSplit_inst (
		.bpm(bpm),
		.ones(ones),
		.tens(tens),
		.hundreds(hundreds)
	);

	displayScan #(
		.ScanDivide(ScanDivide)
	) displayScan_inst (
		.sck(sck),
		.reset(reset),
		.ones(ones),
		.tens(tens),
		.hundreds(hundreds),
		.disp(disp),
		.sevenOut(sevenOut)
	);

endmodule

// ==== verif/tbModel.svh ====
/* Reference model, included inside the testbench module; relies on its localparams.
   One call of modelStep per ADC frame, in frame order. */
`ifndef tbModelSvh
`define tbModelSvh

// filter delay line, index 0 newest
int delayLine [heartPkg::TapCount];
// slope history, index 0 newest, 1 = not rising
bit slopeHist [WindowBits];
int prevFiltered;
int holdLeft;
int peakTotal;
// rate window state
int windowCount;
int windowPeaks;
int bpmNow;

// mirrored taps share one coefficient
function automatic int coefForTap(input int tap);
	int mirror;
	mirror = (tap <= heartPkg::TapCount / 2) ? tap : heartPkg::TapCount - 1 - tap;
	return heartPkg::CoefTable[mirror];
endfunction

// convolution over the whole line, scaled down and clamped
function automatic int firOutput();
	int sum;
	sum = 0;
	for (int i = 0; i < heartPkg::TapCount; i++)
	begin
		sum += coefForTap(i) * delayLine[i];
	end
	sum = sum >> heartPkg::CoefShift;
	return (sum > 1023) ? 1023 : sum;
endfunction

// ones in slopeHist[lo..hi]
function automatic int countOnes(input int lo, input int hi);
	int total;
	total = 0;
	for (int i = lo; i <= hi; i++)
	begin
		total += slopeHist[i];
	end
	return total;
endfunction

// decimal digit at position 0 ones, 1 tens, 2 hundreds
function automatic int decimalDigit(input int value, input int position);
	int scaled;
	scaled = value;
	for (int i = 0; i < position; i++)
	begin
		scaled = scaled / 10;
	end
	return scaled % 10;
endfunction

task automatic modelReset();
	for (int i = 0; i < heartPkg::TapCount; i++)
	begin
		delayLine[i] = 0;
	end
	// history starts full of ones
	for (int i = 0; i < WindowBits; i++)
	begin
		slopeHist[i] = 1'b1;
	end
	prevFiltered = 0;
	holdLeft = 0;
	peakTotal = 0;
	windowCount = 0;
	windowPeaks = 0;
	bpmNow = 0;
endtask

// one sample through filter, slope, peak and rate rules
task automatic modelStep(input int sampleIn);
	int filteredNow;
	int older;
	int newer;
	bit slope;
	bit fire;
	for (int i = heartPkg::TapCount - 1; i > 0; i--)
	begin
		delayLine[i] = delayLine[i-1];
	end
	// new sample counts in this output
	delayLine[0] = sampleIn;
	filteredNow = firOutput();
	slope = (filteredNow <= prevFiltered);
	prevFiltered = filteredNow;
	// peak rule sees the history before this bit
	older = countOnes(WindowBits / 2, WindowBits - 1);
	newer = countOnes(0, WindowBits / 2 - 1);
	fire = (older <= LeftMax) && (newer >= RightMin) && (holdLeft == 0);
	for (int i = WindowBits - 1; i > 0; i--)
	begin
		slopeHist[i] = slopeHist[i-1];
	end
	slopeHist[0] = slope;
	if (fire)
	begin
		holdLeft = HoldSamples;
		peakTotal = (peakTotal + 1) % 256;
	end
	else if (holdLeft > 0)
	begin
		holdLeft--;
	end
	// closing value loads the rate; its own peak lands in the next window
	if (windowCount == WindowSamples - 1)
	begin
		bpmNow = windowPeaks * RateScale;
		if (bpmNow > 999)
		begin
			bpmNow = 999;
		end
		windowCount = 0;
		windowPeaks = fire ? 1 : 0;
	end
	else
	begin
		windowCount++;
		if (fire)
		begin
			windowPeaks++;
		end
	end
endtask

`endif

// ==== verif/heartMonitorTb.sv ====
/* Noisy triangle pulse with a short rate window (200 samples) and a fast scan (8 cycles).
   Frames start on the first sck edge after reset and follow back to back. */
`timescale 1ns/1ps

module heartMonitorTb;

	localparam int WindowBits = 128;
	localparam int LeftMax = 55;
	localparam int RightMin = 40;
	localparam int HoldSamples = 128;
	localparam int WindowSamples = 200;
	localparam int RateScale = 6;
	localparam int ScanDivide = 8;
	localparam int FrameCount = 800;
	// samples per ramp of the triangle
	localparam int RampSamples = 70;
	// edges from last frame bit to the check point
	localparam int CheckDelay = 8;
	// results are in place this many edges after the last bit
	localparam int SettleDelay = 4;

	logic sck;
	logic reset;
	logic sdo;
	logic peakLed;
	heartPkg::countT leds;
	heartPkg::rateT bpm;
	heartPkg::selT disp;
	heartPkg::segT sevenOut;

	// model state after each frame
	int ledsModel [FrameCount];
	bit holdModel [FrameCount];
	int bpmModel [FrameCount];
	bit [31:0] randState;
	int checkCount;
	int ledsErrors;
	int holdErrors;
	int bpmErrors;
	int displayErrors;

	`include "tbModel.svh"

	heartMonitor #(
		.WindowBits(WindowBits),
		.LeftMax(LeftMax),
		.RightMin(RightMin),
		.HoldSamples(HoldSamples),
		.WindowSamples(WindowSamples),
		.RateScale(RateScale),
		.ScanDivide(ScanDivide)
	) heartMonitor_inst (
		.sck(sck),
		.reset(reset),
		.sdo(sdo),
		.peakLed(peakLed),
		.leds(leds),
		.bpm(bpm),
		.disp(disp),
		.sevenOut(sevenOut)
	);

	// 4 ns period
	initial
	begin
		sck = 1'b0;
		forever #2 sck = ~sck;
	end

	function automatic bit [31:0] xorshift(input bit [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// clean pulse shape from 200 up to 760 and back
	function automatic int triangleLevel(input int index);
		int pos;
		pos = index % (2 * RampSamples);
		if (pos < RampSamples)
		begin
			return 200 + 8 * pos;
		end
		return 200 + 8 * (2 * RampSamples - pos);
	endfunction

	// serial frames MSB first with one bit per edge
	task automatic sendFrames();
		heartPkg::frameT frame;
		int level;
		for (int n = 0; n < FrameCount; n++)
		begin
			randState = xorshift(randState);
			level = triangleLevel(n) + int'(randState & 32'd7);
			randState = xorshift(randState);
			// random channel bits on top
			frame = {randState[5:0], heartPkg::sampleT'(level)};
			for (int b = heartPkg::FrameBits - 1; b >= 0; b--)
			begin
				sdo <= frame[b];
				@(posedge sck);
			end
			// last bit taken on this edge
			modelStep(level);
			ledsModel[n] = peakTotal;
			holdModel[n] = (holdLeft != 0);
			bpmModel[n] = bpmNow;
		end
		sdo <= 1'b0;
	endtask

	// c counts edges since reset release and samples on falling edges
	task automatic watchOutputs();
		int n;
		int landed;
		int pos;
		int shownBpm;
		heartPkg::selT dispExp;
		heartPkg::segT segExp;
		for (int c = 0; c <= FrameCount * heartPkg::FrameBits + 12; c++)
		begin
			@(negedge sck);
			if (c == 0)
			begin
				checkCount++;
				if (leds != 0 || bpm != 0 || peakLed != 1'b0 || disp != 3'b110)
				begin
					$display(
						"** Error: reset leds = 0x%0h bpm = 0x%0h peakLed = 0x%0h disp = 0x%0h",
						leds, bpm, peakLed, disp);
					ledsErrors++;
				end
			end
			// frame n ends on edge 16*(n+1)
			if (c >= heartPkg::FrameBits + CheckDelay && c % heartPkg::FrameBits == CheckDelay)
			begin
				n = c / heartPkg::FrameBits - 1;
				checkCount++;
				if (leds != ledsModel[n])
				begin
					$display("** Error: leds = 0x%0h, expected 0x%0h at frame %0d",
						leds, ledsModel[n], n);
					ledsErrors++;
				end
				if (peakLed != holdModel[n])
				begin
					$display("** Error: peakLed = 0x%0h, expected 0x%0h at frame %0d",
						peakLed, holdModel[n], n);
					holdErrors++;
				end
				if (bpm != bpmModel[n])
				begin
					$display("** Error: bpm = 0x%0h, expected 0x%0h at frame %0d",
						bpm, bpmModel[n], n);
					bpmErrors++;
				end
			end
			// mid-slot display sample
			if (c % ScanDivide == ScanDivide / 2)
			begin
				landed = (c - SettleDelay) / heartPkg::FrameBits;
				shownBpm = (landed > 0) ? bpmModel[landed-1] : 0;
				pos = (c / ScanDivide) % 3;
				dispExp = heartPkg::selT'(~(3'b001 << pos));
				segExp = heartPkg::SegTable[decimalDigit(shownBpm, pos)];
				checkCount++;
				if (disp != dispExp)
				begin
					$display("** Error: disp = 0x%0h, expected 0x%0h at edge %0d",
						disp, dispExp, c);
					displayErrors++;
				end
				if (sevenOut != segExp)
				begin
					$display("** Error: sevenOut = 0x%0h, expected 0x%0h at edge %0d",
						sevenOut, segExp, c);
					displayErrors++;
				end
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		sdo = 1'b0;
		randState = 32'h4f90;
		checkCount = 0;
		ledsErrors = 0;
		holdErrors = 0;
		bpmErrors = 0;
		displayErrors = 0;
		modelReset();
		repeat (10) @(posedge sck);
		reset <= 1'b0;
		// stimulus and checks side by side
		fork
			sendFrames();
			watchOutputs();
		join
		$display("checks %0d, errors leds %0d peakLed %0d bpm %0d display %0d",
			checkCount, ledsErrors, holdErrors, bpmErrors, displayErrors);
		if (ledsErrors + holdErrors + bpmErrors + displayErrors == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verif
common/heartPkg.sv
verilog/spiFrameRx.sv
filter/firFilter.sv
peak/peakFinder.sv
verilog/rateCounter.sv
display/digitSplit.sv
display/displayScan.sv
verilog/heartMonitor.sv
verif/heartMonitorTb.sv
